//--- source/sysbus_consts.svh
`ifndef SYSBUS_CONSTS_SVH
`define SYSBUS_CONSTS_SVH

// one bus beat, used for address and data alike
`define SYSBUS_DATA_WIDTH 64

// request and response tag
`define SYSBUS_TAG_WIDTH 13

// beats that make up one cache line
`define SYSBUS_BEATS 8

// tag bit that marks a write request
`define SYSBUS_WRITE_BIT 12

// bytes per line, line index starts above this offset
`define SYSBUS_LINE_BYTES 64

`define SYSBUS_LINE_WIDTH (`SYSBUS_DATA_WIDTH * `SYSBUS_BEATS)

// default depth of the line store
`define MEM_LINES_DEFAULT 64

`endif

//--- source/sysbus_pkg.sv
`include "sysbus_consts.svh"

package sysbus_pkg;

	// one beat on the bus, either an address or data
	typedef logic [`SYSBUS_DATA_WIDTH-1:0] bus_word_t;

	// top bit is the write flag, the rest names the requester
	typedef logic [`SYSBUS_TAG_WIDTH-1:0] bus_tag_t;

	// full cache line, beat n sits in the n-th 64-bit slice
	typedef logic [`SYSBUS_LINE_WIDTH-1:0] line_t;

	// position of a beat inside the line
	typedef logic [$clog2(`SYSBUS_BEATS)-1:0] beat_t;

endpackage

//--- source/ctrl_pkg.sv
package ctrl_pkg;

	// arbiter sequencing, processor side first, then memory side
	typedef enum logic [3:0] {
		arb_accept,
		arb_ack_req,
		arb_read_val,
		arb_ack_val,
		arb_mem_addr,
		arb_mem_write,
		arb_mem_read_wait,
		arb_respond,
		arb_resp_ack
	} arb_state_t;

	// line store sequencing
	typedef enum logic [2:0] {
		mem_idle,
		mem_ack_addr,
		mem_take_beat,
		mem_send_beat,
		mem_wait_ack
	} mem_state_t;

	// channel 0 is instruction fetch, channel 1 is data access
	typedef enum logic {
		chan_0,
		chan_1
	} chan_t;

endpackage

//--- source/sysbus_if.sv
`timescale 1ns/10ps

interface sysbus_if;
	import sysbus_pkg::*;

	// request direction
	logic reqcyc;
	logic reqack;
	bus_word_t req;
	bus_tag_t reqtag;

	// response direction
	logic respcyc;
	logic respack;
	bus_word_t resp;
	bus_tag_t resptag;

	modport requester (
		output reqcyc,
		output req,
		output reqtag,
		output respack,
		input reqack,
		input respcyc,
		input resp,
		input resptag
	);

	modport responder (
		input reqcyc,
		input req,
		input reqtag,
		input respack,
		output reqack,
		output respcyc,
		output resp,
		output resptag
	);

endinterface

//--- source/bus_arbiter.sv
`timescale 1ns/10ps
`include "sysbus_consts.svh"

module bus_arbiter (
	input logic clk,
	input logic reset,

	// channel 0 carries instruction fetch
	input logic reqcyc0,
	input sysbus_pkg::bus_word_t req0,
	input sysbus_pkg::bus_tag_t reqtag0,
	output logic reqack0,
	output logic respcyc0,
	output sysbus_pkg::bus_word_t resp0,
	output sysbus_pkg::bus_tag_t resptag0,
	input logic respack0,

	// channel 1 carries data access
	input logic reqcyc1,
	input sysbus_pkg::bus_word_t req1,
	input sysbus_pkg::bus_tag_t reqtag1,
	output logic reqack1,
	output logic respcyc1,
	output sysbus_pkg::bus_word_t resp1,
	output sysbus_pkg::bus_tag_t resptag1,
	input logic respack1,

	sysbus_if.requester mem
);
	import sysbus_pkg::*;
	import ctrl_pkg::*;

	localparam beat_t last_beat = beat_t'(`SYSBUS_BEATS - 1);

	arb_state_t state;
	beat_t ptr;
	chan_t owner;
	logic mem_respack;

	// latched request and the buffered line
	bus_word_t addr;
	bus_tag_t tag;
	line_t line_buf;

	logic is_write;
	logic own_reqcyc;
	bus_word_t own_req;
	logic own_respack;
	bus_word_t cur_beat;

	assign is_write = tag[`SYSBUS_WRITE_BIT];

	// only the owning channel is looked at once a transaction is open
	assign own_reqcyc = (owner == chan_1) ? reqcyc1 : reqcyc0;
	assign own_req = (owner == chan_1) ? req1 : req0;
	assign own_respack = (owner == chan_1) ? respack1 : respack0;

	assign cur_beat = line_buf[ptr*`SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= arb_accept;
			ptr <= '0;
			owner <= chan_0;
			mem_respack <= 1'b0;
		end else begin
			mem_respack <= 1'b0;
			case (state)
				arb_accept: begin
					ptr <= '0;
					// fixed priority with fetch winning a tie
					if (reqcyc0) begin
						owner <= chan_0;
						state <= arb_ack_req;
					end else if (reqcyc1) begin
						owner <= chan_1;
						state <= arb_ack_req;
					end
				end
				arb_ack_req: begin
					state <= is_write ? arb_read_val : arb_mem_addr;
				end
				arb_read_val: begin
					if (own_reqcyc) begin
						state <= arb_ack_val;
					end
				end
				arb_ack_val: begin
					// ptr wraps to zero after the last beat
					ptr <= ptr + 1'b1;
					state <= (ptr == last_beat) ? arb_mem_addr : arb_read_val;
				end
				arb_mem_addr: begin
					if (mem.reqack) begin
						state <= is_write ? arb_mem_write : arb_mem_read_wait;
					end
				end
				arb_mem_write: begin
					if (mem.reqack) begin
						ptr <= ptr + 1'b1;
						if (ptr == last_beat) begin
							state <= arb_accept;
						end
					end
				end
				arb_mem_read_wait: begin
					// respack is up one cycle per beat and ptr moves while it is up
					if (mem_respack) begin
						ptr <= ptr + 1'b1;
						if (ptr == last_beat) begin
							state <= arb_respond;
						end
					end else if (mem.respcyc) begin
						mem_respack <= 1'b1;
					end
				end
				arb_respond: begin
					if (own_respack) begin
						state <= arb_resp_ack;
					end
				end
				arb_resp_ack: begin
					ptr <= ptr + 1'b1;
					state <= (ptr == last_beat) ? arb_accept : arb_respond;
				end
				default: begin
					state <= arb_accept;
				end
			endcase
		end
	end

	// request fields and line data
	always_ff @(posedge clk) begin
		if (state == arb_accept) begin
			if (reqcyc0) begin
				addr <= req0;
				tag <= reqtag0;
			end else if (reqcyc1) begin
				addr <= req1;
				tag <= reqtag1;
			end
		end
		if (state == arb_read_val && own_reqcyc) begin
			line_buf[ptr*`SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH] <= own_req;
		end
		if (state == arb_mem_read_wait && mem.respcyc && !mem_respack) begin
			line_buf[ptr*`SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH] <= mem.resp;
			// memory echoes the request tag with every beat
			tag <= mem.resptag;
		end
	end

	// processor side outputs decoded from state and owner
	always_comb begin
		reqack0 = 1'b0;
		reqack1 = 1'b0;
		respcyc0 = 1'b0;
		respcyc1 = 1'b0;
		resp0 = '0;
		resp1 = '0;
		resptag0 = '0;
		resptag1 = '0;
		if (state == arb_ack_req || state == arb_ack_val) begin
			if (owner == chan_1) begin
				reqack1 = 1'b1;
			end else begin
				reqack0 = 1'b1;
			end
		end
		if (state == arb_respond) begin
			if (owner == chan_1) begin
				respcyc1 = 1'b1;
				resp1 = cur_beat;
				resptag1 = tag;
			end else begin
				respcyc0 = 1'b1;
				resp0 = cur_beat;
				resptag0 = tag;
			end
		end
	end

	// memory side sends the address beat first and then the buffered line
	assign mem.reqcyc = (state == arb_mem_addr) || (state == arb_mem_write);
	assign mem.req = (state == arb_mem_write) ? cur_beat : addr;
	assign mem.reqtag = tag;
	assign mem.respack = mem_respack;

	// a beat is acknowledged only after its own channel requested it
	a_single_reqack: assert property (@(posedge clk) disable iff (reset)
		reqack0 |-> !reqack1 && $past(reqcyc0));

	a_ack1_requested: assert property (@(posedge clk) disable iff (reset)
		reqack1 |-> $past(reqcyc1));

	// a response never reaches the channel that does not own the line
	a_resp_owner: assert property (@(posedge clk) disable iff (reset)
		(respcyc0 || respcyc1) |-> (respcyc1 == (owner == chan_1)) && !(respcyc0 && respcyc1));

	// no request toward memory is withdrawn before its ack
	a_mem_reqcyc_held: assert property (@(posedge clk) disable iff (reset)
		mem.reqcyc && !mem.reqack |=> mem.reqcyc);

endmodule

//--- source/line_memory.sv
`timescale 1ns/10ps
`include "sysbus_consts.svh"

module line_memory #(
	parameter int LINES = `MEM_LINES_DEFAULT
) (
	input logic clk,
	input logic reset,
	sysbus_if.responder bus
);
	import sysbus_pkg::*;
	import ctrl_pkg::*;

	// depth is a power of two, upper address bits alias
	localparam int off_w = $clog2(`SYSBUS_LINE_BYTES);
	localparam int idx_w = $clog2(LINES);
	localparam beat_t last_beat = beat_t'(`SYSBUS_BEATS - 1);

	line_t store [LINES];
	logic [LINES-1:0] valid;

	mem_state_t state;
	beat_t beat;
	logic reqack;
	logic respcyc;
	logic rd_valid;

	logic [idx_w-1:0] idx;
	bus_tag_t tag;
	line_t wr_line;
	line_t rd_line;

	logic is_write;
	logic store_we;

	assign is_write = tag[`SYSBUS_WRITE_BIT];

	// line is committed in the ack cycle of the last write beat
	assign store_we = (state == mem_take_beat) && reqack && (beat == last_beat);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mem_idle;
			beat <= '0;
			reqack <= 1'b0;
			respcyc <= 1'b0;
			rd_valid <= 1'b0;
			valid <= '0;
		end else begin
			reqack <= 1'b0;
			case (state)
				mem_idle: begin
					beat <= '0;
					if (bus.reqcyc) begin
						reqack <= 1'b1;
						state <= mem_ack_addr;
					end
				end
				mem_ack_addr: begin
					state <= is_write ? mem_take_beat : mem_send_beat;
				end
				mem_take_beat: begin
					if (reqack) begin
						beat <= beat + 1'b1;
						if (beat == last_beat) begin
							valid[idx] <= 1'b1;
							state <= mem_idle;
						end
					end else if (bus.reqcyc) begin
						reqack <= 1'b1;
					end
				end
				mem_send_beat: begin
					// unwritten lines come back as zero
					rd_valid <= valid[idx];
					respcyc <= 1'b1;
					state <= mem_wait_ack;
				end
				mem_wait_ack: begin
					if (bus.respack) begin
						if (beat == last_beat) begin
							respcyc <= 1'b0;
							state <= mem_idle;
						end else begin
							beat <= beat + 1'b1;
						end
					end
				end
				default: begin
					state <= mem_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == mem_idle && bus.reqcyc) begin
			idx <= bus.req[off_w +: idx_w];
			tag <= bus.reqtag;
		end
		if (state == mem_take_beat && bus.reqcyc && !reqack) begin
			wr_line[beat*`SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH] <= bus.req;
		end
		if (store_we) begin
			store[idx] <= wr_line;
		end
		if (state == mem_send_beat) begin
			rd_line <= store[idx];
		end
	end

	assign bus.reqack = reqack;
	assign bus.respcyc = respcyc;
	assign bus.resp = rd_valid ? rd_line[beat*`SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH] : '0;
	assign bus.resptag = tag;

	// a beat under back-pressure stays put
	a_resp_held: assert property (@(posedge clk) disable iff (reset)
		bus.respcyc && !bus.respack |=> $stable(bus.resp) && $stable(bus.resptag));

endmodule

//--- source/sysbus_top.sv
`timescale 1ns/10ps
`include "sysbus_consts.svh"

module sysbus_top #(
	parameter int MEM_LINES = `MEM_LINES_DEFAULT
) (
	input logic clk,
	input logic reset,

	// instruction fetch channel
	input logic reqcyc0,
	input sysbus_pkg::bus_word_t req0,
	input sysbus_pkg::bus_tag_t reqtag0,
	output logic reqack0,
	output logic respcyc0,
	output sysbus_pkg::bus_word_t resp0,
	output sysbus_pkg::bus_tag_t resptag0,
	input logic respack0,

	// data access channel
	input logic reqcyc1,
	input sysbus_pkg::bus_word_t req1,
	input sysbus_pkg::bus_tag_t reqtag1,
	output logic reqack1,
	output logic respcyc1,
	output sysbus_pkg::bus_word_t resp1,
	output sysbus_pkg::bus_tag_t resptag1,
	input logic respack1
);

	// arbiter to line store
	sysbus_if mem_bus ();

	bus_arbiter u_arbiter (
		.clk(clk),
		.reset(reset),
		.reqcyc0(reqcyc0),
		.req0(req0),
		.reqtag0(reqtag0),
		.reqack0(reqack0),
		.respcyc0(respcyc0),
		.resp0(resp0),
		.resptag0(resptag0),
		.respack0(respack0),
		.reqcyc1(reqcyc1),
		.req1(req1),
		.reqtag1(reqtag1),
		.reqack1(reqack1),
		.respcyc1(respcyc1),
		.resp1(resp1),
		.resptag1(resptag1),
		.respack1(respack1),
		.mem(mem_bus)
	);

	line_memory #(
		.LINES(MEM_LINES)
	) u_memory (
		.clk(clk),
		.reset(reset),
		.bus(mem_bus)
	);

endmodule

//--- testbench/sysbus_tb_checks.sv
`timescale 1ns/10ps

module sysbus_tb_checks (
	input logic clk,
	input logic reset,
	input logic reqcyc0,
	input logic reqcyc1,
	input logic reqack0,
	input logic reqack1,
	input logic respcyc0,
	input logic respcyc1,
	input logic respack0,
	input logic respack1,
	input sysbus_pkg::bus_word_t resp0,
	input sysbus_pkg::bus_word_t resp1,
	input sysbus_pkg::bus_tag_t resptag0,
	input sysbus_pkg::bus_tag_t resptag1,
	input sysbus_pkg::bus_word_t exp_beat,
	input sysbus_pkg::bus_tag_t exp_tag,
	input logic rd_active,
	input logic rd_chan,
	input logic tie_test,
	output logic err
);
	import sysbus_pkg::*;

	logic seen_req;
	logic ack0_seen;
	logic sel_cyc;
	logic sel_ack;
	logic other_cyc;
	bus_word_t sel_resp;
	bus_tag_t sel_tag;

	// the channel being read, and the one that must stay quiet
	assign sel_cyc = rd_chan ? respcyc1 : respcyc0;
	assign sel_ack = rd_chan ? respack1 : respack0;
	assign sel_resp = rd_chan ? resp1 : resp0;
	assign sel_tag = rd_chan ? resptag1 : resptag0;
	assign other_cyc = rd_chan ? respcyc0 : respcyc1;

	initial err = 1'b0;

	always_ff @(posedge clk) begin
		if (reset) begin
			seen_req <= 1'b0;
			ack0_seen <= 1'b0;
		end else begin
			if (reqcyc0 || reqcyc1) begin
				seen_req <= 1'b1;
			end
			ack0_seen <= tie_test && (ack0_seen || reqack0);
		end
	end

	a_quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
		!seen_req |-> !reqack0 && !reqack1 && !respcyc0 && !respcyc1)
	else begin
		$display("%0t: processor outputs active before any request", $time);
		err = 1'b1;
	end

	a_resp_data: assert property (@(posedge clk) disable iff (reset)
		rd_active && sel_cyc && sel_ack |-> sel_resp == exp_beat)
	else begin
		$display("MISMATCH at %0t: resp%0d expected %h actual %h", $time,
			$sampled(rd_chan), $sampled(exp_beat), $sampled(sel_resp));
		err = 1'b1;
	end

	a_resp_tag: assert property (@(posedge clk) disable iff (reset)
		rd_active && sel_cyc && sel_ack |-> sel_tag == exp_tag)
	else begin
		$display("MISMATCH at %0t: resptag%0d expected %h actual %h", $time,
			$sampled(rd_chan), $sampled(exp_tag), $sampled(sel_tag));
		err = 1'b1;
	end

	// back-pressure, beat held until respack
	a_resp_held: assert property (@(posedge clk) disable iff (reset)
		rd_active && sel_cyc && !sel_ack |=> sel_cyc && $stable(sel_resp) && $stable(sel_tag))
	else begin
		$display("%0t: response on channel %0d dropped or changed before respack",
			$time, rd_chan);
		err = 1'b1;
	end

	a_other_quiet: assert property (@(posedge clk) disable iff (reset)
		rd_active |-> !other_cyc)
	else begin
		$display("%0t: respcyc raised on the channel that is not reading", $time);
		err = 1'b1;
	end

	a_fetch_first: assert property (@(posedge clk) disable iff (reset)
		tie_test && reqack1 |-> ack0_seen)
	else begin
		$display("%0t: channel 1 acknowledged ahead of channel 0 on a tie", $time);
		err = 1'b1;
	end

endmodule

//--- testbench/sysbus_tb.sv
`timescale 1ns/10ps
`include "sysbus_consts.svh"

module sysbus_tb;
	import sysbus_pkg::*;

	localparam int timeout_cycles = 200;

	logic clk;
	logic reset;
	logic reqcyc0;
	logic reqcyc1;
	bus_word_t req0;
	bus_word_t req1;
	bus_tag_t reqtag0;
	bus_tag_t reqtag1;
	logic reqack0;
	logic reqack1;
	logic respcyc0;
	logic respcyc1;
	bus_word_t resp0;
	bus_word_t resp1;
	bus_tag_t resptag0;
	bus_tag_t resptag1;
	logic respack0;
	logic respack1;

	// expected response and test phase, seen by the checker
	bus_word_t exp_beat;
	bus_tag_t exp_tag;
	logic rd_active;
	logic rd_chan;
	logic tie_test;
	logic check_err;

	logic [31:0] lfsr;
	line_t ref_mem [bus_word_t];

	sysbus_top u_sysbus_top (.*);

	sysbus_tb_checks u_checks (.*, .err(check_err));

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "simulation stopped");
	endtask

	// one LFSR step per bit taken, taps 32 22 2 1
	function automatic bus_word_t take_bits(input int n);
		bus_word_t val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[`SYSBUS_DATA_WIDTH-2:0], fb};
		end
		return val;
	endfunction

	function automatic line_t random_line();
		line_t l;
		for (int b = 0; b < `SYSBUS_BEATS; b++) begin
			l[b*`SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH] = take_bits(`SYSBUS_DATA_WIDTH);
		end
		return l;
	endfunction

	// line aligned and inside the default depth, so no aliasing
	function automatic bus_word_t random_addr();
		return take_bits(6) * `SYSBUS_LINE_BYTES;
	endfunction

	function automatic logic dut_flag(input int ch, input bit resp_side);
		if (resp_side) begin
			return (ch == 1) ? respcyc1 : respcyc0;
		end
		return (ch == 1) ? reqack1 : reqack0;
	endfunction

	task automatic wait_for_flag(input int ch, input bit resp_side);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!dut_flag(ch, resp_side) && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (!dut_flag(ch, resp_side)) begin
			abort_run($sformatf("timeout waiting for %s on channel %0d",
				resp_side ? "respcyc" : "reqack", ch));
		end
	endtask

	task automatic drive_req(input int ch, input logic cyc, input bus_word_t word,
			input bus_tag_t tag);
		if (ch == 1) begin
			reqcyc1 = cyc;
			req1 = word;
			reqtag1 = tag;
		end else begin
			reqcyc0 = cyc;
			req0 = word;
			reqtag0 = tag;
		end
	endtask

	task automatic write_line(input int ch, input bus_word_t addr, input line_t data);
		bus_tag_t tag;
		tag = bus_tag_t'(addr / `SYSBUS_LINE_BYTES);
		tag[`SYSBUS_WRITE_BIT] = 1'b1;
		drive_req(ch, 1'b1, addr, tag);
		wait_for_flag(ch, 1'b0);
		for (int b = 0; b < `SYSBUS_BEATS; b++) begin
			drive_req(ch, 1'b1, data[b*`SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH], tag);
			wait_for_flag(ch, 1'b0);
		end
		drive_req(ch, 1'b0, '0, '0);
		ref_mem[addr] = data;
	endtask

	task automatic read_line(input int ch, input bus_word_t addr);
		bus_tag_t tag;
		line_t exp_line;
		int delay;
		// write bit stays clear with only 12 bits taken
		tag = bus_tag_t'(take_bits(12));
		exp_line = ref_mem.exists(addr) ? ref_mem[addr] : '0;
		rd_chan = (ch == 1);
		rd_active = 1'b1;
		exp_tag = tag;
		drive_req(ch, 1'b1, addr, tag);
		wait_for_flag(ch, 1'b0);
		drive_req(ch, 1'b0, '0, '0);
		for (int b = 0; b < `SYSBUS_BEATS; b++) begin
			wait_for_flag(ch, 1'b1);
			delay = int'(take_bits(2));
			repeat (delay) @(negedge clk);
			exp_beat = exp_line[b*`SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH];
			respack0 = (ch == 0);
			respack1 = (ch == 1);
			@(negedge clk);
			respack0 = 1'b0;
			respack1 = 1'b0;
		end
		rd_active = 1'b0;
	endtask

	initial begin
		@(posedge check_err);
		abort_run("checker assertion failed");
	end

	initial begin
		bus_word_t a;
		bus_word_t b;
		lfsr = 32'h3918;
		reset = 1'b1;
		drive_req(0, 1'b0, '0, '0);
		drive_req(1, 1'b0, '0, '0);
		respack0 = 1'b0;
		respack1 = 1'b0;
		exp_beat = '0;
		exp_tag = '0;
		rd_active = 1'b0;
		rd_chan = 1'b0;
		tie_test = 1'b0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		repeat (4) @(negedge clk);

		// nothing written yet, so any line reads as zero
		read_line(0, random_addr());

		a = random_addr();
		write_line(1, a, random_line());
		read_line(0, a);

		// simultaneous requests, fetch goes first
		a = random_addr();
		b = a ^ `SYSBUS_LINE_BYTES;
		tie_test = 1'b1;
		fork
			write_line(0, a, random_line());
			write_line(1, b, random_line());
		join
		tie_test = 1'b0;
		read_line(1, a);
		read_line(0, b);

		for (int i = 0; i < 6; i++) begin
			a = random_addr();
			write_line(i % 2, a, random_line());
			read_line((i + 1) % 2, a);
		end

		// final sweep over every line written
		foreach (ref_mem[k]) begin
			read_line(int'(k[6]), k);
		end

		if (!check_err) begin
			$display("All tests passed!");
			$finish;
		end else begin
			abort_run("checker flagged an error before the end of the run");
		end
	end

endmodule

//--- sysbus.f
+incdir+source
source/sysbus_pkg.sv
source/ctrl_pkg.sv
source/sysbus_if.sv
source/bus_arbiter.sv
source/line_memory.sv
source/sysbus_top.sv
testbench/sysbus_tb_checks.sv
testbench/sysbus_tb.sv
